//--- dec8b10bTop.f
+incdir+verification
src/dec8b10bPkg.sv
src/subblock6bDecoder.sv
src/subblock4bDecoder.sv
src/symbolCombiner.sv
src/apbLinkStatus.sv
src/dec8b10bTop.sv
verification/dec8b10bTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = dec8b10bTb
FILELIST  = dec8b10bTop.f
OBJDIR    = obj_dir
SIMBIN    = $(OBJDIR)/V$(TOP)
PASSMSG   = NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the run passes only if the simulation printed the pass line
run: compile
	@out="$$(./$(SIMBIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

//--- verification/encoderModel.svh
`ifndef ENCODER_MODEL_SVH
`define ENCODER_MODEL_SVH

// 5b/6b codes as sent under running disparity minus, abcdei with a in bit 5
localparam logic [5:0] code6Minus [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// 3b/4b codes under minus, fghj with f in bit 3, primary D.x.7
localparam logic [3:0] code4Minus [8] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
};

function automatic logic [5:0] code6(input logic [4:0] x, input logic rdIn);
    logic [5:0] c;
    c = code6Minus[x];
    if (rdIn == dec8b10bPkg::rdPlus && ($countones(c) != 3 || c == 6'b111000)) begin
        c = ~c;     // plus side is the complement, except for the balanced codes
    end
    return c;
endfunction

function automatic logic [3:0] code4(input logic [2:0] x, input logic [4:0] x5, input logic rdIn);
    logic [3:0] c;
    logic       alt;
    alt = (x == 3'd7) &&
          ((rdIn == dec8b10bPkg::rdMinus && (x5 == 5'd17 || x5 == 5'd18 || x5 == 5'd20)) ||
           (rdIn == dec8b10bPkg::rdPlus && (x5 == 5'd11 || x5 == 5'd13 || x5 == 5'd14)));
    c = alt ? 4'b0111 : code4Minus[x];  // alternate 7 avoids a run of five
    if (rdIn == dec8b10bPkg::rdPlus && ($countones(c) != 2 || c == 4'b1100)) begin
        c = ~c;
    end
    return c;
endfunction

function automatic logic [9:0] encodeSymbol(input logic [7:0] b, input logic rdIn);
    logic [5:0] s6;
    logic       rdMid;
    s6    = code6(b[4:0], rdIn);
    rdMid = ($countones(s6) == 3) ? rdIn : ($countones(s6) > 3);
    return {code4(b[7:5], b[4:0], rdMid), s6};
endfunction

// line rules by ones count, result is {rule broken, disparity after the symbol}
function automatic logic [1:0] lineCheck(input logic [9:0] sym, input logic rdIn);
    int   n6;
    int   n4;
    logic err;
    logic r;
    n6  = $countones(sym[5:0]);
    n4  = $countones(sym[9:6]);
    err = 1'b0;
    r   = rdIn;
    if (n6 > 3 || sym[5:0] == 6'b111000) begin
        err = (r != dec8b10bPkg::rdMinus);
    end else if (n6 < 3 || sym[5:0] == 6'b000111) begin
        err = (r != dec8b10bPkg::rdPlus);
    end
    if (n6 != 3) begin
        r = (n6 > 3);
    end
    if (n4 > 2 || sym[9:6] == 4'b1100) begin
        err = err | (r != dec8b10bPkg::rdMinus);
    end else if (n4 < 2 || sym[9:6] == 4'b0011) begin
        err = err | (r != dec8b10bPkg::rdPlus);
    end
    if (n4 != 2) begin
        r = (n4 > 2);
    end
    return {err, r};
endfunction

`endif

//--- verification/dec8b10bTb.sv
`default_nettype none
`timescale 1ns/1ps

module dec8b10bTb;

    localparam int rstCycles   = 8;
    localparam int symbolTotal = 512 + 2 + 300 + 16 + 16 + 1;
    localparam int apbCycles   = 16 * 3;
    localparam int timeLimitNs = (rstCycles + symbolTotal + apbCycles + 100) * 100;

    logic        CLK;
    logic        rstN;
    logic [9:0]  symbol;
    logic        symbolValid;
    logic [7:0]  dataByte;
    logic        dataValid;
    logic        codeErr;
    logic        dispErr;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        rd;        // running disparity as the encoder model sees it
    int          seed;

    `include "encoderModel.svh"

    dec8b10bTop dut_i (
        .CLK         (CLK),
        .rstN        (rstN),
        .symbol      (symbol),
        .symbolValid (symbolValid),
        .dataByte    (dataByte),
        .dataValid   (dataValid),
        .codeErr     (codeErr),
        .dispErr     (dispErr),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    always #50 CLK = ~CLK;

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // called 5 ns after an edge, returns 5 ns after the edge that registered the result
    task automatic sendSymbol(input logic [9:0] sym, input logic [7:0] expByte,
                              input logic expCode, input logic expDisp);
        symbol      = sym;
        symbolValid = 1'b1;
        @(posedge CLK);
        #5;
        checkValue(dataValid, 1, "dataValid");
        if (!expCode) begin
            checkValue(dataByte, expByte, "dataByte");
        end
        checkValue(codeErr, expCode, "codeErr");
        checkValue(dispErr, expDisp, "dispErr");
    endtask

    task automatic sendByte(input logic [7:0] b);
        logic [9:0] sym;
        logic [1:0] res;
        sym = encodeSymbol(b, rd);
        res = lineCheck(sym, rd);
        rd  = res[0];
        sendSymbol(sym, b, 1'b0, 1'b0);
    endtask

    // zero wait states, so pready must be up in the first access cycle
    task automatic apbTransfer(input logic [7:0] addr, input logic write,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        @(posedge CLK);
        #5;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge CLK);
        #5;
        penable = 1'b1;
        checkValue(pready, 1, "pready in access phase");
        rdata = prdata;
        err   = pslverr;
        @(posedge CLK);     // the write lands on this edge
        #5;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        checkValue(pready, 0, "pready after access phase");
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apbTransfer(addr, 1'b0, 32'd0, data, err);
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apbTransfer(addr, 1'b1, data, unused, err);
    endtask

    task automatic expectReg(input logic [7:0] addr, input logic [31:0] expected,
                             input string what);
        logic [31:0] data;
        logic        err;
        apbRead(addr, data, err);
        checkValue(data, expected, what);
        checkValue(err, 0, "pslverr on a valid read");
    endtask

    task automatic clearCounters();
        logic err;
        apbWrite(dec8b10bPkg::regStatus, 32'd0, err);
        checkValue(err, 0, "pslverr on status write");
    endtask

    task automatic resetState();
        checkValue(dataValid, 0, "dataValid after reset");
        checkValue(codeErr, 0, "codeErr after reset");
        checkValue(dispErr, 0, "dispErr after reset");
        checkValue(pready, 0, "pready after reset");
        checkValue(pslverr, 0, "pslverr after reset");
        expectReg(dec8b10bPkg::regCodeErrCount, 0, "code error count after reset");
        expectReg(dec8b10bPkg::regDispErrCount, 0, "disparity error count after reset");
        expectReg(dec8b10bPkg::regSymbolCount, 0, "symbol count after reset");
    endtask

    task automatic exhaustiveDecode();
        for (int i = 0; i < 256; i++) begin
            sendByte(8'(i));
        end
        while (rd != dec8b10bPkg::rdPlus) begin
            sendByte(8'h20);    // D.0.1 leaves plus when sent from minus
        end
        for (int i = 0; i < 256; i++) begin
            sendByte(8'(i));
        end
        symbolValid = 1'b0;
    endtask

    task automatic randomStream();
        int r;
        clearCounters();
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            sendByte(r[7:0]);
        end
        symbolValid = 1'b0;
        expectReg(dec8b10bPkg::regSymbolCount, 300, "symbol count");
    endtask

    task automatic codeErrors();
        clearCounters();
        for (int i = 0; i < 8; i++) begin
            sendSymbol({4'b1001, 6'b111111}, 8'h00, 1'b1, 1'b0);
            sendSymbol({4'b0000, 6'b110001}, 8'h00, 1'b1, 1'b0);
        end
        symbolValid = 1'b0;
        expectReg(dec8b10bPkg::regCodeErrCount, 16, "code error count");
    endtask

    task automatic dispErrors();
        logic [9:0] sym;
        logic [1:0] res;
        int         expErrs;
        clearCounters();
        expErrs = 0;
        for (int i = 0; i < 8; i++) begin
            sym = encodeSymbol(8'h20, rd);
            for (int k = 0; k < 2; k++) begin
                res = lineCheck(sym, rd);
                rd  = res[0];
                expErrs += int'(res[1]);
                sendSymbol(sym, 8'h20, 1'b0, res[1]);
            end
        end
        symbolValid = 1'b0;
        expectReg(dec8b10bPkg::regDispErrCount, expErrs, "disparity error count");
        expectReg(dec8b10bPkg::regStatus, {30'd0, 1'b1, rd}, "status after errors");
    endtask

    task automatic clearAndApb();
        logic [31:0] data;
        logic        err;
        // one bad code so that every counter holds a nonzero value before the clear
        sendSymbol({4'b1001, 6'b111111}, 8'h00, 1'b1, 1'b0);
        symbolValid = 1'b0;
        apbWrite(dec8b10bPkg::regStatus, 32'hFFFF_FFFF, err);
        checkValue(err, 0, "pslverr on status write");
        expectReg(dec8b10bPkg::regCodeErrCount, 0, "code error count after clear");
        expectReg(dec8b10bPkg::regDispErrCount, 0, "disparity error count after clear");
        expectReg(dec8b10bPkg::regSymbolCount, 0, "symbol count after clear");
        expectReg(dec8b10bPkg::regStatus, {30'd0, 1'b0, rd}, "status after clear");
        apbRead(8'h10, data, err);
        checkValue(err, 1, "pslverr on unused address");
    endtask

    initial begin
        #(timeLimitNs);
        $display("timeout: the tests did not finish within %0d ns", timeLimitNs);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        CLK         = 1'b0;
        rstN        = 1'b0;
        symbol      = '0;
        symbolValid = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        rd          = dec8b10bPkg::rdMinus;
        seed        = 32'h2d268ef9;
        repeat (rstCycles) @(posedge CLK);
        #5;
        rstN = 1'b1;
        resetState();
        exhaustiveDecode();
        randomStream();
        codeErrors();
        dispErrors();
        clearAndApb();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/dec8b10bTop.sv
`default_nettype none
`timescale 1ns/1ps

module dec8b10bTop (
    input  logic                 CLK,
    input  logic                 rstN,
    input  dec8b10bPkg::symbolT  symbol,
    input  logic                 symbolValid,
    output dec8b10bPkg::byteT    dataByte,
    output logic                 dataValid,
    output logic                 codeErr,
    output logic                 dispErr,
    input  dec8b10bPkg::apbAddrT paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  dec8b10bPkg::apbDataT pwdata,
    output dec8b10bPkg::apbDataT prdata,
    output logic                 pready,
    output logic                 pslverr
);

    logic [4:0]             lo5;
    logic                   lo5Valid;
    dec8b10bPkg::dispClassT lo6Class;
    logic [2:0]             hi3;
    logic                   hi3Valid;
    dec8b10bPkg::dispClassT hi4Class;
    logic                   runDisp;
    logic                   symbolSeen;
    logic                   codeErrSeen;
    logic                   dispErrSeen;

    subblock6bDecoder lo_i (
        .sub6     (symbol[5:0]),    // abcdei
        .lo5      (lo5),
        .lo5Valid (lo5Valid),
        .lo6Class (lo6Class)
    );

    subblock4bDecoder hi_i (
        .sub4     (symbol[9:6]),    // fghj
        .hi3      (hi3),
        .hi3Valid (hi3Valid),
        .hi4Class (hi4Class)
    );

    symbolCombiner comb_i (
        .CLK         (CLK),
        .rstN        (rstN),
        .symbolValid (symbolValid),
        .lo5         (lo5),
        .lo5Valid    (lo5Valid),
        .lo6Class    (lo6Class),
        .hi3         (hi3),
        .hi3Valid    (hi3Valid),
        .hi4Class    (hi4Class),
        .dataByte    (dataByte),
        .dataValid   (dataValid),
        .codeErr     (codeErr),
        .dispErr     (dispErr),
        .runDisp     (runDisp),
        .symbolSeen  (symbolSeen),
        .codeErrSeen (codeErrSeen),
        .dispErrSeen (dispErrSeen)
    );

    apbLinkStatus apb_i (
        .CLK         (CLK),
        .rstN        (rstN),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .runDisp     (runDisp),
        .symbolSeen  (symbolSeen),
        .codeErrSeen (codeErrSeen),
        .dispErrSeen (dispErrSeen),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

endmodule

`default_nettype wire

//--- src/apbLinkStatus.sv
`default_nettype none
`timescale 1ns/1ps

module apbLinkStatus (
    input  logic                 CLK,
    input  logic                 rstN,
    input  dec8b10bPkg::apbAddrT paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  dec8b10bPkg::apbDataT pwdata,
    input  logic                 runDisp,
    input  logic                 symbolSeen,
    input  logic                 codeErrSeen,
    input  logic                 dispErrSeen,
    output dec8b10bPkg::apbDataT prdata,
    output logic                 pready,
    output logic                 pslverr
);

    dec8b10bPkg::countT codeErrCount;
    dec8b10bPkg::countT dispErrCount;
    dec8b10bPkg::countT symbolCount;
    logic               stickyErr;
    logic               setupPhase;
    logic               accessPhase;
    logic               addrOk;
    logic               clearReq;

    function automatic dec8b10bPkg::countT bump(input dec8b10bPkg::countT value,
                                                input logic hit);
        if (hit && value != dec8b10bPkg::countMax) begin
            return value + 1'b1;
        end
        return value;
    endfunction

    assign setupPhase  = psel & ~penable;
    assign accessPhase = psel & penable;
    assign clearReq    = accessPhase & pwrite & (paddr == dec8b10bPkg::regStatus);

    // read mux, valid as soon as the address is on the bus
    always_comb begin
        prdata = '0;
        addrOk = 1'b1;
        case (paddr)
            dec8b10bPkg::regStatus:       prdata = {30'd0, stickyErr, runDisp};
            dec8b10bPkg::regCodeErrCount: prdata = {16'd0, codeErrCount};
            dec8b10bPkg::regDispErrCount: prdata = {16'd0, dispErrCount};
            dec8b10bPkg::regSymbolCount:  prdata = {16'd0, symbolCount};
            default:                      addrOk = 1'b0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pready       <= 1'b0;
            pslverr      <= 1'b0;
            codeErrCount <= '0;
            dispErrCount <= '0;
            symbolCount  <= '0;
            stickyErr    <= 1'b0;
        end else begin
            pready  <= setupPhase;              // setup now means access next cycle
            pslverr <= setupPhase & ~addrOk;
            if (clearReq) begin
                codeErrCount <= '0;             // clear beats a same-cycle bump
                dispErrCount <= '0;
                symbolCount  <= '0;
                stickyErr    <= 1'b0;
            end else begin
                codeErrCount <= bump(codeErrCount, codeErrSeen);
                dispErrCount <= bump(dispErrCount, dispErrSeen);
                symbolCount  <= bump(symbolCount, symbolSeen);
                stickyErr    <= stickyErr | codeErrSeen | dispErrSeen;
            end
        end
    end

    readyInAccess: assert property (@(posedge CLK) disable iff (!rstN)
        pready |-> (psel && penable));

    // Master must hold write data stable and defined during the access phase
    wdataKnown: assert property (@(posedge CLK) disable iff (!rstN)
        (accessPhase && pwrite) |-> !$isunknown(pwdata));

endmodule

`default_nettype wire

//--- src/symbolCombiner.sv
`default_nettype none
`timescale 1ns/1ps

module symbolCombiner (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic                   symbolValid,
    input  logic [4:0]             lo5,
    input  logic                   lo5Valid,
    input  dec8b10bPkg::dispClassT lo6Class,
    input  logic [2:0]             hi3,
    input  logic                   hi3Valid,
    input  dec8b10bPkg::dispClassT hi4Class,
    output dec8b10bPkg::byteT      dataByte,
    output logic                   dataValid,
    output logic                   codeErr,
    output logic                   dispErr,
    output logic                   runDisp,
    output logic                   symbolSeen,
    output logic                   codeErrSeen,
    output logic                   dispErrSeen
);

    logic       bothValid;
    logic [1:0] step6;      // {rule broken, disparity after the 6b subblock}
    logic [1:0] step4;      // same for the 4b subblock

    // one subblock against the incoming disparity, the class still moves it
    function automatic logic [1:0] applyClass(input dec8b10bPkg::dispClassT cls,
                                              input logic rdIn);
        logic err;
        logic rdOut;
        err   = 1'b0;
        rdOut = rdIn;
        case (cls)
            dec8b10bPkg::dispPositive: begin
                err   = (rdIn != dec8b10bPkg::rdMinus);
                rdOut = dec8b10bPkg::rdPlus;
            end
            dec8b10bPkg::dispNegative: begin
                err   = (rdIn != dec8b10bPkg::rdPlus);
                rdOut = dec8b10bPkg::rdMinus;
            end
            dec8b10bPkg::dispNeedsMinus: err = (rdIn != dec8b10bPkg::rdMinus);
            dec8b10bPkg::dispNeedsPlus:  err = (rdIn != dec8b10bPkg::rdPlus);
            default: err = 1'b0;
        endcase
        return {err, rdOut};
    endfunction

    assign bothValid = lo5Valid & hi3Valid;
    assign step6     = applyClass(lo6Class, runDisp);
    assign step4     = applyClass(hi4Class, step6[0]);   // 4b sees the mid-symbol disparity

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            dataValid <= 1'b0;
            codeErr   <= 1'b0;
            dispErr   <= 1'b0;
            runDisp   <= dec8b10bPkg::rdMinus;
        end else begin
            dataValid <= symbolValid;
            codeErr   <= symbolValid & ~bothValid;
            dispErr   <= symbolValid & bothValid & (step6[1] | step4[1]);
            if (symbolValid && bothValid) begin
                runDisp <= step4[0];    // a bad code keeps the old disparity
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (symbolValid) begin
            dataByte <= {hi3, lo5};
        end
    end

    // the counters see the same registered events as the data port
    assign symbolSeen  = dataValid;
    assign codeErrSeen = codeErr;
    assign dispErrSeen = dispErr;

    errOnlyWithData: assert property (@(posedge CLK) disable iff (!rstN)
        (codeErr || dispErr) |-> dataValid);

    quietAfterReset: assert property (@(posedge CLK) !rstN |=> !dataValid);

endmodule

`default_nettype wire

//--- src/subblock4bDecoder.sv
`default_nettype none
`timescale 1ns/1ps

module subblock4bDecoder (
    input  dec8b10bPkg::sub4T      sub4,
    output logic [2:0]             hi3,
    output logic                   hi3Valid,
    output dec8b10bPkg::dispClassT hi4Class
);

    logic [6:0] row;    // valid flag, decoded bits and class

    always_comb begin
        case (sub4)
            4'b1011: row = {1'b1, 3'd0, dec8b10bPkg::dispPositive};
            4'b0100: row = {1'b1, 3'd0, dec8b10bPkg::dispNegative};
            4'b1001: row = {1'b1, 3'd1, dec8b10bPkg::dispNeutral};
            4'b0101: row = {1'b1, 3'd2, dec8b10bPkg::dispNeutral};
            4'b1100: row = {1'b1, 3'd3, dec8b10bPkg::dispNeedsMinus};
            4'b0011: row = {1'b1, 3'd3, dec8b10bPkg::dispNeedsPlus};
            4'b1101: row = {1'b1, 3'd4, dec8b10bPkg::dispPositive};
            4'b0010: row = {1'b1, 3'd4, dec8b10bPkg::dispNegative};
            4'b1010: row = {1'b1, 3'd5, dec8b10bPkg::dispNeutral};
            4'b0110: row = {1'b1, 3'd6, dec8b10bPkg::dispNeutral};
            4'b1110: row = {1'b1, 3'd7, dec8b10bPkg::dispPositive};
            4'b0001: row = {1'b1, 3'd7, dec8b10bPkg::dispNegative};
            // alternate D.x.7, accepted without checking the 6b neighbour
            4'b0111: row = {1'b1, 3'd7, dec8b10bPkg::dispPositive};
            4'b1000: row = {1'b1, 3'd7, dec8b10bPkg::dispNegative};
            default: row = {1'b0, 3'd0, dec8b10bPkg::dispNeutral};    // 0000 and 1111
        endcase
    end

    assign hi3Valid = row[6];
    assign hi3      = row[5:3];
    assign hi4Class = dec8b10bPkg::dispClassT'(row[2:0]);

endmodule

`default_nettype wire

//--- src/subblock6bDecoder.sv
`default_nettype none
`timescale 1ns/1ps

module subblock6bDecoder (
    input  dec8b10bPkg::sub6T      sub6,
    output logic [4:0]             lo5,
    output logic                   lo5Valid,
    output dec8b10bPkg::dispClassT lo6Class
);

    logic [8:0] row;    // valid flag, decoded bits and class of the matched code

    // both forms of each code, the minus-side form first
    always_comb begin
        case (sub6)
            6'b100111: row = {1'b1, 5'd0, dec8b10bPkg::dispPositive};
            6'b011000: row = {1'b1, 5'd0, dec8b10bPkg::dispNegative};
            6'b011101: row = {1'b1, 5'd1, dec8b10bPkg::dispPositive};
            6'b100010: row = {1'b1, 5'd1, dec8b10bPkg::dispNegative};
            6'b101101: row = {1'b1, 5'd2, dec8b10bPkg::dispPositive};
            6'b010010: row = {1'b1, 5'd2, dec8b10bPkg::dispNegative};
            6'b110001: row = {1'b1, 5'd3, dec8b10bPkg::dispNeutral};
            6'b110101: row = {1'b1, 5'd4, dec8b10bPkg::dispPositive};
            6'b001010: row = {1'b1, 5'd4, dec8b10bPkg::dispNegative};
            6'b101001: row = {1'b1, 5'd5, dec8b10bPkg::dispNeutral};
            6'b011001: row = {1'b1, 5'd6, dec8b10bPkg::dispNeutral};
            6'b111000: row = {1'b1, 5'd7, dec8b10bPkg::dispNeedsMinus};  // balanced but one-sided
            6'b000111: row = {1'b1, 5'd7, dec8b10bPkg::dispNeedsPlus};
            6'b111001: row = {1'b1, 5'd8, dec8b10bPkg::dispPositive};
            6'b000110: row = {1'b1, 5'd8, dec8b10bPkg::dispNegative};
            6'b100101: row = {1'b1, 5'd9, dec8b10bPkg::dispNeutral};
            6'b010101: row = {1'b1, 5'd10, dec8b10bPkg::dispNeutral};
            6'b110100: row = {1'b1, 5'd11, dec8b10bPkg::dispNeutral};
            6'b001101: row = {1'b1, 5'd12, dec8b10bPkg::dispNeutral};
            6'b101100: row = {1'b1, 5'd13, dec8b10bPkg::dispNeutral};
            6'b011100: row = {1'b1, 5'd14, dec8b10bPkg::dispNeutral};
            6'b010111: row = {1'b1, 5'd15, dec8b10bPkg::dispPositive};
            6'b101000: row = {1'b1, 5'd15, dec8b10bPkg::dispNegative};
            6'b011011: row = {1'b1, 5'd16, dec8b10bPkg::dispPositive};
            6'b100100: row = {1'b1, 5'd16, dec8b10bPkg::dispNegative};
            6'b100011: row = {1'b1, 5'd17, dec8b10bPkg::dispNeutral};
            6'b010011: row = {1'b1, 5'd18, dec8b10bPkg::dispNeutral};
            6'b110010: row = {1'b1, 5'd19, dec8b10bPkg::dispNeutral};
            6'b001011: row = {1'b1, 5'd20, dec8b10bPkg::dispNeutral};
            6'b101010: row = {1'b1, 5'd21, dec8b10bPkg::dispNeutral};
            6'b011010: row = {1'b1, 5'd22, dec8b10bPkg::dispNeutral};
            6'b111010: row = {1'b1, 5'd23, dec8b10bPkg::dispPositive};
            6'b000101: row = {1'b1, 5'd23, dec8b10bPkg::dispNegative};
            6'b110011: row = {1'b1, 5'd24, dec8b10bPkg::dispPositive};
            6'b001100: row = {1'b1, 5'd24, dec8b10bPkg::dispNegative};
            6'b100110: row = {1'b1, 5'd25, dec8b10bPkg::dispNeutral};
            6'b010110: row = {1'b1, 5'd26, dec8b10bPkg::dispNeutral};
            6'b110110: row = {1'b1, 5'd27, dec8b10bPkg::dispPositive};
            6'b001001: row = {1'b1, 5'd27, dec8b10bPkg::dispNegative};
            6'b001110: row = {1'b1, 5'd28, dec8b10bPkg::dispNeutral};
            6'b101110: row = {1'b1, 5'd29, dec8b10bPkg::dispPositive};
            6'b010001: row = {1'b1, 5'd29, dec8b10bPkg::dispNegative};
            6'b011110: row = {1'b1, 5'd30, dec8b10bPkg::dispPositive};
            6'b100001: row = {1'b1, 5'd30, dec8b10bPkg::dispNegative};
            6'b101011: row = {1'b1, 5'd31, dec8b10bPkg::dispPositive};
            6'b010100: row = {1'b1, 5'd31, dec8b10bPkg::dispNegative};
            default:   row = {1'b0, 5'd0, dec8b10bPkg::dispNeutral};   // K codes land here too
        endcase
    end

    assign lo5Valid = row[8];
    assign lo5      = row[7:3];
    assign lo6Class = dec8b10bPkg::dispClassT'(row[2:0]);

    // a clean subblock must always yield a defined class for the combiner
    always_comb begin
        if (!$isunknown(sub6)) begin
            assert (!$isunknown(lo6Class))
                else $error("6b class unknown for known subblock %b", sub6);
        end
    end

endmodule

`default_nettype wire

//--- src/dec8b10bPkg.sv
`default_nettype none

package dec8b10bPkg;

    // line symbol, fghj sits in bits 9:6 and abcdei in bits 5:0
    typedef logic [9:0] symbolT;
    typedef logic [7:0] byteT;
    typedef logic [5:0] sub6T;      // abcdei, a in bit 5
    typedef logic [3:0] sub4T;      // fghj, f in bit 3
    typedef logic [15:0] countT;
    typedef logic [7:0] apbAddrT;
    typedef logic [31:0] apbDataT;

    // effect of one subblock on the running disparity
    typedef enum logic [2:0] {
        dispNeutral    = 3'd0,      // balanced, legal under either disparity
        dispPositive   = 3'd1,      // more ones, needs minus and leaves plus
        dispNegative   = 3'd2,      // more zeros, needs plus and leaves minus
        dispNeedsMinus = 3'd3,      // 111000 or 1100
        dispNeedsPlus  = 3'd4       // 000111 or 0011
    } dispClassT;

    // running disparity encoding, status bit 0 uses the same values
    localparam logic rdMinus = 1'b0;
    localparam logic rdPlus  = 1'b1;

    localparam countT countMax = '1;    // counters stick here

    localparam apbAddrT regStatus       = 8'h00;  // a write of any value clears counters
    localparam apbAddrT regCodeErrCount = 8'h04;
    localparam apbAddrT regDispErrCount = 8'h08;
    localparam apbAddrT regSymbolCount  = 8'h0C;

endpackage

`default_nettype wire
